/* design/test_mem_pkg.sv */
package test_mem_pkg;

  //------------------------------
  // Memory geometry
  //------------------------------

  // Physical size in bytes, wider addresses wrap onto it
  localparam int mem_size_bytes = 256;

  // Message widths
  localparam int data_width = 32;
  localparam int addr_width = 8;

  // One block is one data word
  localparam int bytes_per_word = data_width / 8;
  localparam int num_words      = mem_size_bytes / bytes_per_word;

  //------------------------------
  // Message field types
  //------------------------------

  typedef logic [0:0] msg_type_t;

  localparam msg_type_t msg_read  = 1'b0;
  localparam msg_type_t msg_write = 1'b1;

  typedef logic [addr_width-1:0] msg_addr_t;

  // Zero encodes a full-word access
  typedef logic [$clog2(bytes_per_word)-1:0] msg_len_t;

  // Decoded length, one bit wider so a full word fits
  typedef logic [$clog2(bytes_per_word):0] eff_len_t;

  typedef logic [data_width-1:0] msg_data_t;

  // Block index and byte position inside a block
  typedef logic [$clog2(num_words)-1:0]      word_addr_t;
  typedef logic [$clog2(bytes_per_word)-1:0] byte_offset_t;
  typedef logic [bytes_per_word-1:0]         byte_mask_t;

  //------------------------------
  // Messages
  //------------------------------

  typedef struct packed {
    msg_type_t msg_type;
    msg_addr_t addr;
    msg_len_t  len;
    msg_data_t data;
  } mem_req_t;

  // Type and len are echoed from the request
  typedef struct packed {
    msg_type_t msg_type;
    msg_len_t  len;
    msg_data_t data;
  } mem_resp_t;

  // Port stage to array
  typedef struct packed {
    word_addr_t   word_addr;
    byte_offset_t offset;
    byte_mask_t   wr_mask;
    msg_data_t    wr_data;   // already placed in its byte lanes
  } array_access_t;

endpackage

/* design/mem_port_stage.sv */
module mem_port_stage (
  input  logic                        clk_i,
  input  logic                        reset_i,

  // Request channel
  input  logic                        memreq_val_i,
  output logic                        memreq_rdy_o,
  input  test_mem_pkg::mem_req_t      memreq_msg_i,

  // Response channel
  output logic                        memresp_val_o,
  input  logic                        memresp_rdy_i,
  output test_mem_pkg::mem_resp_t     memresp_msg_o,

  // Shared array side
  output test_mem_pkg::array_access_t access_o,
  output logic                        wr_en_o,
  input  test_mem_pkg::msg_data_t     rd_word_i
);
  import test_mem_pkg::*;

  logic                               val_q;
  mem_req_t                           req_q;

  logic [$clog2(mem_size_bytes)-1:0]  phys_addr;
  word_addr_t                         word_addr;
  byte_offset_t                       offset;
  eff_len_t                           eff_len;
  byte_mask_t                         wr_mask;
  msg_data_t                          wr_data;
  logic                               resp_fire;

  //------------------------------
  // Request register
  //------------------------------

  // Whole stage stalls while the response side is not ready
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      val_q <= 1'b0;
    end else if (memresp_rdy_i) begin
      val_q <= memreq_val_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (memresp_rdy_i) begin
      req_q <= memreq_msg_i;
    end
  end

  // Strict pipeline, ready goes straight back upstream
  assign memreq_rdy_o = memresp_rdy_i;

  //------------------------------
  // Address and length decode
  //------------------------------

  // Drop address bits beyond the physical memory
  assign phys_addr = req_q.addr[$clog2(mem_size_bytes)-1:0];

  assign word_addr = word_addr_t'(phys_addr >> $clog2(bytes_per_word));
  assign offset    = byte_offset_t'(phys_addr);

  // Length zero means the whole word
  assign eff_len = (req_q.len == '0) ? eff_len_t'(bytes_per_word)
                                     : eff_len_t'(req_q.len);

  // Bytes from offset up to offset+len-1, clipped at the block end
  always_comb begin
    wr_mask = '0;
    for (int b = 0; b < bytes_per_word; b++) begin
      if (b >= int'(offset) && b < int'(offset) + int'(eff_len)) begin
        wr_mask[b] = 1'b1;
      end
    end
  end

  // Move the low data bytes up to the addressed lanes
  assign wr_data = req_q.data << {offset, 3'b000};

  always_comb begin
    access_o.word_addr = word_addr;
    access_o.offset    = offset;
    access_o.wr_mask   = wr_mask;
    access_o.wr_data   = wr_data;
  end

  //------------------------------
  // Response
  //------------------------------

  assign memresp_val_o = val_q;
  assign resp_fire     = val_q && memresp_rdy_i;

  // Commit only on the accepted cycle so a stalled write never repeats
  assign wr_en_o = resp_fire && (req_q.msg_type == msg_write);

  // Block shifted down by the offset, zeros from the top.
  // For a write this is the block before the write lands
  always_comb begin
    memresp_msg_o.msg_type = req_q.msg_type;
    memresp_msg_o.len      = req_q.len;
    memresp_msg_o.data     = rd_word_i >> {offset, 3'b000};
  end

endmodule

/* design/mem_array.sv */
module mem_array (
  input  logic                        clk_i,

  // Block selects and write payload from each port stage
  input  test_mem_pkg::array_access_t port0_access_i,
  input  test_mem_pkg::array_access_t port1_access_i,
  input  logic                        port0_wr_en_i,
  input  logic                        port1_wr_en_i,

  // Raw block contents, before this edge's writes
  output test_mem_pkg::msg_data_t     port0_rd_word_o,
  output test_mem_pkg::msg_data_t     port1_rd_word_o
);
  import test_mem_pkg::*;

  msg_data_t     mem [num_words];

  // Ports gathered in priority order, last entry wins
  array_access_t acc [2];
  logic [1:0]    wr_en;

  assign acc[0] = port0_access_i;
  assign acc[1] = port1_access_i;

  assign wr_en = {port1_wr_en_i, port0_wr_en_i};

  //------------------------------
  // Read ports
  //------------------------------

  // Combinational, zero latency
  assign port0_rd_word_o = mem[port0_access_i.word_addr];
  assign port1_rd_word_o = mem[port1_access_i.word_addr];

  //------------------------------
  // Write ports
  //------------------------------

  // Byte lanes are written in port order, so port 1 overrides port 0
  // where both touch the same byte of the same block
  always_ff @(posedge clk_i) begin
    for (int p = 0; p < $size(acc); p++) begin
      if (wr_en[p]) begin
        for (int b = 0; b < bytes_per_word; b++) begin
          if (acc[p].wr_mask[b]) begin
            mem[acc[p].word_addr][b*8 +: 8] <= acc[p].wr_data[b*8 +: 8];
          end
        end
      end
    end
  end

endmodule

/* design/test_mem_dual_port.sv */
module test_mem_dual_port (
  input  logic                    clk,
  input  logic                    reset,

  // Port 0
  input  logic                    memreq0_val_i,
  output logic                    memreq0_rdy_o,
  input  test_mem_pkg::mem_req_t  memreq0_msg_i,

  output logic                    memresp0_val_o,
  input  logic                    memresp0_rdy_i,
  output test_mem_pkg::mem_resp_t memresp0_msg_o,

  // Port 1
  input  logic                    memreq1_val_i,
  output logic                    memreq1_rdy_o,
  input  test_mem_pkg::mem_req_t  memreq1_msg_i,

  output logic                    memresp1_val_o,
  input  logic                    memresp1_rdy_i,
  output test_mem_pkg::mem_resp_t memresp1_msg_o
);
  import test_mem_pkg::*;

  array_access_t port0_access;
  array_access_t port1_access;
  logic          port0_wr_en;
  logic          port1_wr_en;
  msg_data_t     port0_rd_word;
  msg_data_t     port1_rd_word;

  //------------------------------
  // Per-port request stages
  //------------------------------

  mem_port_stage port0_stage (
    .clk_i         (clk),
    .reset_i       (reset),
    .memreq_val_i  (memreq0_val_i),
    .memreq_rdy_o  (memreq0_rdy_o),
    .memreq_msg_i  (memreq0_msg_i),
    .memresp_val_o (memresp0_val_o),
    .memresp_rdy_i (memresp0_rdy_i),
    .memresp_msg_o (memresp0_msg_o),
    .access_o      (port0_access),
    .wr_en_o       (port0_wr_en),
    .rd_word_i     (port0_rd_word)
  );

  mem_port_stage port1_stage (
    .clk_i         (clk),
    .reset_i       (reset),
    .memreq_val_i  (memreq1_val_i),
    .memreq_rdy_o  (memreq1_rdy_o),
    .memreq_msg_i  (memreq1_msg_i),
    .memresp_val_o (memresp1_val_o),
    .memresp_rdy_i (memresp1_rdy_i),
    .memresp_msg_o (memresp1_msg_o),
    .access_o      (port1_access),
    .wr_en_o       (port1_wr_en),
    .rd_word_i     (port1_rd_word)
  );

  //------------------------------
  // Shared storage
  //------------------------------

  mem_array array (
    .clk_i           (clk),
    .port0_access_i  (port0_access),
    .port1_access_i  (port1_access),
    .port0_wr_en_i   (port0_wr_en),
    .port1_wr_en_i   (port1_wr_en),
    .port0_rd_word_o (port0_rd_word),
    .port1_rd_word_o (port1_rd_word)
  );

endmodule

/* testbench/tb_clock_gen.sv */
module tb_clock_gen (
  output logic clk_o,
  output logic reset_o
);
  timeunit 1ns;
  timeprecision 1ps;

  localparam int clk_period   = 100;
  localparam int reset_cycles = 10;

  initial begin
    clk_o = 1'b0;
    forever #(clk_period / 2) clk_o = ~clk_o;
  end

  // Synchronous reset, released just after a rising edge
  initial begin
    reset_o = 1'b1;
    repeat (reset_cycles) @(posedge clk_o);
    #10 reset_o = 1'b0;
  end

endmodule

/* testbench/test_mem_asserts.sv */
module test_mem_asserts (
  input logic                    clk_i,
  input logic                    reset_i,
  input logic                    req0_rdy_i,
  input logic                    req1_rdy_i,
  input logic                    resp0_val_i,
  input logic                    resp1_val_i,
  input logic                    resp0_rdy_i,
  input logic                    resp1_rdy_i,
  input test_mem_pkg::mem_resp_t resp0_msg_i,
  input test_mem_pkg::mem_resp_t resp1_msg_i,
  input logic                    wr0_en_i,
  input logic                    wr1_en_i
);
  timeunit 1ns;
  timeprecision 1ps;

  // Strict pipeline, request ready mirrors response ready
  req0_ready_through: assert property (@(posedge clk_i) req0_rdy_i == resp0_rdy_i)
    else $error("Port 0 request ready differs from response ready");

  req1_ready_through: assert property (@(posedge clk_i) req1_rdy_i == resp1_rdy_i)
    else $error("Port 1 request ready differs from response ready");

  resp_idle_after_reset: assert property (
    @(posedge clk_i) reset_i |=> !resp0_val_i && !resp1_val_i)
    else $error("Response valid high in the cycle after reset");

  // A write from the other port may legally change the held read data
  resp0_hold: assert property (@(posedge clk_i) disable iff (reset_i)
    resp0_val_i && !resp0_rdy_i && !wr1_en_i |=> resp0_val_i && $stable(resp0_msg_i))
    else $error("Port 0 stalled response changed");

  resp1_hold: assert property (@(posedge clk_i) disable iff (reset_i)
    resp1_val_i && !resp1_rdy_i && !wr0_en_i |=> resp1_val_i && $stable(resp1_msg_i))
    else $error("Port 1 stalled response changed");

endmodule

bind test_mem_dual_port test_mem_asserts asserts (
  .clk_i       (clk),
  .reset_i     (reset),
  .req0_rdy_i  (memreq0_rdy_o),
  .req1_rdy_i  (memreq1_rdy_o),
  .resp0_val_i (memresp0_val_o),
  .resp1_val_i (memresp1_val_o),
  .resp0_rdy_i (memresp0_rdy_i),
  .resp1_rdy_i (memresp1_rdy_i),
  .resp0_msg_i (memresp0_msg_o),
  .resp1_msg_i (memresp1_msg_o),
  .wr0_en_i    (port0_wr_en),
  .wr1_en_i    (port1_wr_en)
);

/* testbench/tb_test_mem.sv */
module tb_test_mem;
  timeunit 1ns;
  timeprecision 1ps;

  import test_mem_pkg::*;

  localparam int seed           = 23;
  localparam int num_ports      = 2;
  localparam int clk_period     = 100;
  localparam int drive_delay    = 10;
  localparam int test_cycles    = 2000;
  // Random phase plus ten percent for reset, fill and drain
  localparam int timeout_cycles = test_cycles + test_cycles / 10;

  logic      clk;
  logic      reset;

  logic      req_val  [num_ports];
  mem_req_t  req_msg  [num_ports];
  logic      req_rdy  [num_ports];
  logic      resp_val [num_ports];
  logic      resp_rdy [num_ports];
  mem_resp_t resp_msg [num_ports];

  // Reference model state
  logic [7:0] model_mem   [mem_size_bytes];
  logic       model_known [mem_size_bytes];
  mem_req_t   exp_req     [num_ports];
  logic       pending     [num_ports];
  logic       taken       [num_ports];
  int         errors;

  tb_clock_gen clock_gen (
    .clk_o   (clk),
    .reset_o (reset)
  );

  test_mem_dual_port uut (
    .clk            (clk),
    .reset          (reset),
    .memreq0_val_i  (req_val[0]),
    .memreq0_rdy_o  (req_rdy[0]),
    .memreq0_msg_i  (req_msg[0]),
    .memresp0_val_o (resp_val[0]),
    .memresp0_rdy_i (resp_rdy[0]),
    .memresp0_msg_o (resp_msg[0]),
    .memreq1_val_i  (req_val[1]),
    .memreq1_rdy_o  (req_rdy[1]),
    .memreq1_msg_i  (req_msg[1]),
    .memresp1_val_o (resp_val[1]),
    .memresp1_rdy_i (resp_rdy[1]),
    .memresp1_msg_o (resp_msg[1])
  );

  //------------------------------
  // Helpers
  //------------------------------

  task automatic report_error(input string msg);
    errors++;
    $display("[ERROR] %0t ns: %s", $time, msg);
    $display("sim failed");
    $fatal(1, "Stopping at first error");
  endtask

  function automatic mem_req_t random_request();
    mem_req_t req;
    req.msg_type = msg_type_t'($urandom_range(0, 1));
    // Half the traffic goes to a small window so the ports collide
    if ($urandom_range(0, 1) == 1) begin
      req.addr = msg_addr_t'($urandom_range(0, 15));
    end else begin
      req.addr = msg_addr_t'($urandom());
    end
    req.len  = msg_len_t'($urandom());
    req.data = msg_data_t'($urandom());
    return req;
  endfunction

  function automatic void apply_write(input mem_req_t req);
    int phys;
    int off;
    int len;
    phys = int'(req.addr) % mem_size_bytes;
    off  = phys % bytes_per_word;
    len  = (req.len == 0) ? bytes_per_word : int'(req.len);
    for (int i = 0; i < len; i++) begin
      // Bytes past the block end are dropped
      if (off + i < bytes_per_word) begin
        model_mem[phys + i]   = req.data[8*i +: 8];
        model_known[phys + i] = 1'b1;
      end
    end
  endfunction

  task automatic check_response(input int p);
    int         phys;
    int         off;
    logic [7:0] got;
    phys = int'(exp_req[p].addr) % mem_size_bytes;
    off  = phys % bytes_per_word;
    assert (resp_msg[p].msg_type === exp_req[p].msg_type &&
            resp_msg[p].len === exp_req[p].len)
      else report_error($sformatf("port %0d type/len %0d/%0d, expected %0d/%0d", p,
                                  resp_msg[p].msg_type, resp_msg[p].len,
                                  exp_req[p].msg_type, exp_req[p].len));
    for (int i = 0; i < bytes_per_word; i++) begin
      got = resp_msg[p].data[8*i +: 8];
      if (off + i >= bytes_per_word) begin
        assert (got === 8'h00)
          else report_error($sformatf("port %0d addr %0h byte %0d is %0h, expected zero fill",
                                      p, exp_req[p].addr, i, got));
      end else if (model_known[phys + i]) begin
        assert (got === model_mem[phys + i])
          else report_error($sformatf("port %0d addr %0h byte %0d is %0h, expected %0h",
                                      p, exp_req[p].addr, i, got, model_mem[phys + i]));
      end
    end
  endtask

  //------------------------------
  // Reference model
  //------------------------------

  // Handshakes are decided by values that are stable at the falling edge
  always @(negedge clk) begin : model_update
    logic fire [num_ports];
    if (!reset) begin
      for (int p = 0; p < num_ports; p++) begin
        assert (req_rdy[p] === resp_rdy[p])
          else report_error($sformatf("port %0d request ready %b, expected %b",
                                      p, req_rdy[p], resp_rdy[p]));
        assert (resp_val[p] === pending[p])
          else report_error($sformatf("port %0d response valid %b, expected %b",
                                      p, resp_val[p], pending[p]));
        if (pending[p]) begin
          check_response(p);
        end
        fire[p] = pending[p] && resp_rdy[p];
      end
      // Port 0 goes first so port 1 wins on shared bytes
      for (int p = 0; p < num_ports; p++) begin
        if (fire[p] && exp_req[p].msg_type == msg_write) begin
          apply_write(exp_req[p]);
        end
      end
      for (int p = 0; p < num_ports; p++) begin
        taken[p] = req_val[p] && resp_rdy[p];
        if (fire[p]) begin
          pending[p] = 1'b0;
        end
        if (taken[p]) begin
          exp_req[p] = req_msg[p];
          pending[p] = 1'b1;
        end
      end
    end
  end

  //------------------------------
  // Stimulus
  //------------------------------

  initial begin
    errors = 0;
    for (int p = 0; p < num_ports; p++) begin
      req_val[p]  = 1'b0;
      req_msg[p]  = '0;
      resp_rdy[p] = 1'b0;
      pending[p]  = 1'b0;
      taken[p]    = 1'b0;
    end
    for (int a = 0; a < mem_size_bytes; a++) begin
      model_known[a] = 1'b0;
    end
    void'($urandom(seed));

    wait (reset == 1'b0);

    // Fill every word through port 0
    for (int w = 0; w < num_words; w++) begin
      @(posedge clk);
      #drive_delay;
      resp_rdy[0] = 1'b1;
      resp_rdy[1] = 1'b1;
      req_val[0]  = 1'b1;
      req_msg[0]  = '{msg_type: msg_write, addr: msg_addr_t'(w * bytes_per_word),
                      len: '0, data: msg_data_t'($urandom())};
    end
    @(posedge clk);
    #drive_delay;
    req_val[0] = 1'b0;

    // Random traffic where a request is held until it is taken
    for (int c = 0; c < test_cycles; c++) begin
      @(posedge clk);
      #drive_delay;
      for (int p = 0; p < num_ports; p++) begin
        if (!req_val[p] || taken[p]) begin
          req_val[p] = ($urandom_range(0, 3) != 0);
          req_msg[p] = random_request();
        end
        resp_rdy[p] = ($urandom_range(0, 3) != 0);
      end
    end

    // Drain
    @(posedge clk);
    #drive_delay;
    for (int p = 0; p < num_ports; p++) begin
      req_val[p]  = 1'b0;
      resp_rdy[p] = 1'b1;
    end
    while (pending[0] || pending[1]) begin
      @(posedge clk);
    end
    @(negedge clk);
    @(posedge clk);

    if (errors == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

  // Watchdog
  initial begin
    #(timeout_cycles * clk_period);
    $display("Timeout: the test did not finish within %0d cycles", timeout_cycles);
    $display("sim failed");
    $fatal(1, "Watchdog expired");
  end

endmodule

/* tb.f */
design/test_mem_pkg.sv
design/mem_port_stage.sv
design/mem_array.sv
design/test_mem_dual_port.sv
testbench/tb_clock_gen.sv
testbench/test_mem_asserts.sv
testbench/tb_test_mem.sv

/* Bender.yml */
package:
  name: test_mem_dual_port

sources:
  # Design, package first
  - files:
      - design/test_mem_pkg.sv
      - design/mem_port_stage.sv
      - design/mem_array.sv
      - design/test_mem_dual_port.sv

  # Testbench
  - target: test
    files:
      - testbench/tb_clock_gen.sv
      - testbench/test_mem_asserts.sv
      - testbench/tb_test_mem.sv
